// File: build.f
+incdir+include
hdl/dense_grad_pkg.sv
hdl/dense_inner.sv
hdl/dense_backward_grad.sv
hdl/grad_ram.sv
hdl/dense_grad_regs.sv
hdl/dense_grad_top.sv
test/dense_grad_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module dense_grad_tb -f build.f

out=$(./obj_dir/Vdense_grad_tb)
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

// File: test/dense_grad_tb.sv
`include "dense_grad_map.svh"

module dense_grad_tb;

  import dense_grad_pkg::*;

  localparam int GRAD_LANES = 8;
  localparam int WAIT_MAX   = 200;
  localparam int GRD_N      = HID_DIM * CHAR_NUM;

  logic    clk = 1'b0;
  logic    rst_n;
  logic    wb_cyc;
  logic    wb_stb;
  logic    wb_we;
  wb_adr_t wb_adr;
  wb_dat_t wb_dat_w;
  wb_dat_t wb_dat_r;
  logic    wb_ack;

  // shadow copies of what the host loaded and what memory should hold
  act_t   act_sh   [BATCH_N][HID_DIM];
  delta_t delta_sh [BATCH_N][CHAR_NUM];
  grad_t  grad_sh  [GRD_N];

  int tests_run    = 0;
  int tests_failed = 0;
  int mismatches   = 0;

  dense_grad_top #(.GRAD_LANES(GRAD_LANES)) dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  always #2 clk = ~clk;

  // --------------------------------------------------
  // bus access
  // --------------------------------------------------
  task automatic stop_on_timeout(input string what);
    $display("timeout: no response while %s", what);
    $display("*** FAILED ***");
    $finish;
  endtask

  // ack and read data taken on the falling edge
  task automatic wb_cycle(input logic we, input wb_adr_t adr, input wb_dat_t dat,
                          output wb_dat_t rd);
    int cnt;
    cnt = 0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    @(negedge clk);
    while (!wb_ack && cnt < WAIT_MAX) begin
      cnt++;
      @(negedge clk);
    end
    if (wb_ack) begin
      rd = wb_dat_r;
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
    end else begin
      stop_on_timeout($sformatf("waiting for wb_ack at address %h", adr));
    end
  endtask

  task automatic wb_write(input wb_adr_t adr, input wb_dat_t dat);
    wb_dat_t unused;
    wb_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input wb_adr_t adr, output wb_dat_t rd);
    wb_cycle(1'b0, adr, '0, rd);
  endtask

  task automatic wait_done();
    wb_dat_t st;
    int polls;
    polls = 0;
    wb_read(`DG_STATUS_ADDR, st);
    while (!st[`DG_STAT_DONE] && polls < WAIT_MAX) begin
      polls++;
      wb_read(`DG_STATUS_ADDR, st);
    end
    if (!st[`DG_STAT_DONE]) begin
      stop_on_timeout("polling STATUS for the done bit");
    end
  endtask

  function automatic wb_dat_t ctrl_value(input logic start, input logic accum);
    wb_dat_t v;
    v = '0;
    v[`DG_CTRL_START] = start;
    v[`DG_CTRL_ACCUM] = accum;
    return v;
  endfunction

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  // batch sum in wide precision, then shift and keep 16 bits
  function automatic grad_t dot_ref(input int h, input int c);
    longint sum;
    sum = 0;
    for (int n = 0; n < BATCH_N; n++) begin
      sum += longint'(act_sh[n][h]) * longint'(delta_sh[n][c]);
    end
    return grad_t'(sum >>> FRAC_BITS);
  endfunction

  task automatic apply_pass(input logic accum);
    int idx;
    for (int h = 0; h < HID_DIM; h++) begin
      for (int c = 0; c < CHAR_NUM; c++) begin
        idx = h * CHAR_NUM + c;
        if (accum) begin
          grad_sh[idx] = grad_sh[idx] + dot_ref(h, c);
        end else begin
          grad_sh[idx] = dot_ref(h, c);
        end
      end
    end
  endtask

  function automatic act_t small_rand();
    return act_t'(int'($urandom() % 1024) - 512);
  endfunction

  task automatic fill_random();
    for (int n = 0; n < BATCH_N; n++) begin
      for (int h = 0; h < HID_DIM; h++) begin
        act_sh[n][h] = small_rand();
      end
      for (int c = 0; c < CHAR_NUM; c++) begin
        delta_sh[n][c] = small_rand();
      end
    end
  endtask

  task automatic load_operands();
    for (int n = 0; n < BATCH_N; n++) begin
      for (int h = 0; h < HID_DIM; h++) begin
        wb_write(`DG_ACT_BASE + wb_adr_t'(n * HID_DIM + h), wb_dat_t'(act_sh[n][h]));
      end
      for (int c = 0; c < CHAR_NUM; c++) begin
        wb_write(`DG_DELTA_BASE + wb_adr_t'(n * CHAR_NUM + c), wb_dat_t'(delta_sh[n][c]));
      end
    end
  endtask

  // --------------------------------------------------
  // checks and reporting
  // --------------------------------------------------
  task automatic check_word(input string name, input wb_dat_t exp, input wb_dat_t got,
                            inout int errs);
    assert (got === exp) else begin
      $display("Error: %s expected %h actual %h", name, exp, got);
      errs++;
    end
  endtask

  // expected read value is the gradient sign-extended to 32 bits
  task automatic check_grads(input string name, inout int errs);
    wb_dat_t rd;
    for (int i = 0; i < GRD_N; i++) begin
      wb_read(`DG_GRAD_BASE + wb_adr_t'(i), rd);
      check_word($sformatf("%s grad[%0d]", name, i),
                 {{(WB_DAT_W-16){grad_sh[i][15]}}, grad_sh[i]}, rd, errs);
    end
  endtask

  task automatic end_test(input string name, input int errs);
    tests_run++;
    mismatches += errs;
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d mismatches", name, errs);
    end
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin
    wb_dat_t rd;
    act_t    poke;
    int      errs;
    void'($urandom(32'h4b4c535d));
    rst_n    <= 1'b0;
    wb_cyc   <= 1'b0;
    wb_stb   <= 1'b0;
    wb_we    <= 1'b0;
    wb_adr   <= '0;
    wb_dat_w <= '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    errs = 0;
    wb_read(`DG_STATUS_ADDR, rd);
    check_word("reset_regs STATUS", 32'h0, rd, errs);
    wb_write(`DG_CTRL_ADDR, ctrl_value(1'b0, 1'b1));
    wb_read(`DG_CTRL_ADDR, rd);
    check_word("reset_regs CTRL set", ctrl_value(1'b0, 1'b1), rd, errs);
    wb_write(`DG_CTRL_ADDR, ctrl_value(1'b0, 1'b0));
    wb_read(`DG_CTRL_ADDR, rd);
    check_word("reset_regs CTRL clear", 32'h0, rd, errs);
    end_test("reset_regs", errs);

    errs = 0;
    fill_random();
    load_operands();
    wb_write(`DG_CTRL_ADDR, ctrl_value(1'b1, 1'b0));
    wait_done();
    apply_pass(1'b0);
    check_grads("overwrite_pass", errs);
    end_test("overwrite_pass", errs);

    errs = 0;
    fill_random();
    load_operands();
    wb_write(`DG_CTRL_ADDR, ctrl_value(1'b1, 1'b1));
    wait_done();
    apply_pass(1'b1);
    check_grads("accumulate_pass", errs);
    end_test("accumulate_pass", errs);

    // same buffers again, the last hidden index issues late in the pass
    errs = 0;
    wb_write(`DG_CTRL_ADDR, ctrl_value(1'b1, 1'b0));
    wb_read(`DG_STATUS_ADDR, rd);
    check_word("busy_guard STATUS", 32'h1 << `DG_STAT_BUSY, rd, errs);
    poke = act_sh[0][HID_DIM-1] + 16'sh0100;
    wb_write(`DG_ACT_BASE + wb_adr_t'(HID_DIM - 1), wb_dat_t'(poke));
    wait_done();
    apply_pass(1'b0);
    check_grads("busy_guard", errs);
    end_test("busy_guard", errs);

    // h 0 with c 0 sums four products of 2^30
    errs = 0;
    for (int n = 0; n < BATCH_N; n++) begin
      for (int h = 0; h < HID_DIM; h++) begin
        act_sh[n][h] = (h == 0 || (n + h) % 2 == 1) ? 16'sh8000 : 16'sh7fff;
      end
      for (int c = 0; c < CHAR_NUM; c++) begin
        delta_sh[n][c] = (c == 0 || (n + c) % 3 == 0) ? 16'sh8000 : 16'sh7fff;
      end
    end
    load_operands();
    wb_write(`DG_CTRL_ADDR, ctrl_value(1'b1, 1'b0));
    wait_done();
    apply_pass(1'b0);
    check_grads("extreme_values", errs);
    end_test("extreme_values", errs);

    $display("tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, mismatches);
    if (tests_failed == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: hdl/dense_grad_top.sv
module dense_grad_top #(
  parameter int GRAD_LANES = 8
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  dense_grad_pkg::wb_adr_t  wb_adr,
  input  dense_grad_pkg::wb_dat_t  wb_dat_w,
  output dense_grad_pkg::wb_dat_t  wb_dat_r,
  output logic                     wb_ack
);

  import dense_grad_pkg::*;

  localparam int ADDR_W = $clog2(HID_DIM * CHAR_NUM / GRAD_LANES);
  localparam int WORD_W = GRAD_LANES * DATA_W;

  // register block to engine
  logic              run;
  logic              accumulate;
  logic              eng_done;
  act_buf_t          act_buf;
  delta_buf_t        delta_buf;

  // engine and host ports of the gradient memory
  logic [ADDR_W-1:0] raddr, waddr, host_raddr;
  logic [WORD_W-1:0] rdata, wdata, host_rdata;
  logic              wen;

  dense_grad_regs #(.GRAD_LANES(GRAD_LANES)) u_regs (
    .clk        (clk),        .rst_n      (rst_n),
    .wb_cyc     (wb_cyc),     .wb_stb     (wb_stb),
    .wb_we      (wb_we),      .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),   .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),     .run        (run),
    .accumulate (accumulate), .act_buf    (act_buf),
    .delta_buf  (delta_buf),  .done       (eng_done),
    .host_raddr (host_raddr), .host_rdata (host_rdata)
  );

  dense_backward_grad #(.GRAD_LANES(GRAD_LANES)) u_engine (
    .clk        (clk),        .rst_n      (rst_n),
    .run        (run),        .accumulate (accumulate),
    .act_buf    (act_buf),    .delta_buf  (delta_buf),
    .raddr      (raddr),      .rdata      (rdata),
    .wen        (wen),        .waddr      (waddr),
    .wdata      (wdata),      .done       (eng_done)
  );

  grad_ram #(.GRAD_LANES(GRAD_LANES)) u_ram (
    .clk        (clk),        .raddr      (raddr),
    .rdata      (rdata),      .wen        (wen),
    .waddr      (waddr),      .wdata      (wdata),
    .host_raddr (host_raddr), .host_rdata (host_rdata)
  );

endmodule

// File: hdl/dense_grad_regs.sv
`include "dense_grad_map.svh"

module dense_grad_regs #(
  parameter  int GRAD_LANES = 8,
  localparam int ADDR_W = $clog2(dense_grad_pkg::HID_DIM * dense_grad_pkg::CHAR_NUM / GRAD_LANES),
  localparam int WORD_W = GRAD_LANES * dense_grad_pkg::DATA_W
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        wb_cyc,
  input  logic                        wb_stb,
  input  logic                        wb_we,
  input  dense_grad_pkg::wb_adr_t     wb_adr,
  input  dense_grad_pkg::wb_dat_t     wb_dat_w,
  output dense_grad_pkg::wb_dat_t     wb_dat_r,
  output logic                        wb_ack,
  output logic                        run,
  output logic                        accumulate,
  output dense_grad_pkg::act_buf_t    act_buf,
  output dense_grad_pkg::delta_buf_t  delta_buf,
  input  logic                        done,
  output logic [ADDR_W-1:0]           host_raddr,
  input  logic [WORD_W-1:0]           host_rdata
);

  import dense_grad_pkg::*;

  localparam int ACT_N     = BATCH_N * HID_DIM;
  localparam int DLT_N     = BATCH_N * CHAR_NUM;
  localparam int GRD_N     = HID_DIM * CHAR_NUM;
  localparam int ACT_IDX_W = $clog2(ACT_N);
  localparam int DLT_IDX_W = $clog2(DLT_N);
  localparam int GRD_IDX_W = $clog2(GRD_N);
  localparam int LANE_W    = $clog2(GRAD_LANES);

  typedef enum logic {IDLE, RUNNING} state_t;

  state_t                 state;
  logic                   req, grad_wait, start_req, done_flag;
  logic                   is_ctrl, is_status, is_act, is_delta, is_grad;
  logic [ACT_IDX_W-1:0]   act_idx;
  logic [DLT_IDX_W-1:0]   dlt_idx;
  logic [GRD_IDX_W-1:0]   grd_idx;
  logic [LANE_W-1:0]      lane_sel;
  grad_t                  sel_grad;
  wb_dat_t                ctrl_word, status_word;

  // --------------------------------------------------
  // address decode
  // --------------------------------------------------
  assign req       = wb_cyc & wb_stb & ~wb_ack & ~grad_wait;
  assign is_ctrl   = (wb_adr == `DG_CTRL_ADDR);
  assign is_status = (wb_adr == `DG_STATUS_ADDR);
  assign is_act    = (wb_adr >= `DG_ACT_BASE) && (wb_adr < `DG_ACT_BASE + ACT_N);
  assign is_delta  = (wb_adr >= `DG_DELTA_BASE) && (wb_adr < `DG_DELTA_BASE + DLT_N);
  assign is_grad   = (wb_adr >= `DG_GRAD_BASE) && (wb_adr < `DG_GRAD_BASE + GRD_N);
  assign act_idx   = ACT_IDX_W'(wb_adr - `DG_ACT_BASE);
  assign dlt_idx   = DLT_IDX_W'(wb_adr - `DG_DELTA_BASE);
  assign grd_idx   = GRD_IDX_W'(wb_adr - `DG_GRAD_BASE);

  // word holding the element, lane picked after the read
  assign host_raddr = grd_idx[GRD_IDX_W-1:LANE_W];
  assign sel_grad   = host_rdata[lane_sel*DATA_W +: DATA_W];

  always_comb begin
    ctrl_word                    = '0;
    ctrl_word[`DG_CTRL_ACCUM]    = accumulate;
    status_word                  = '0;
    status_word[`DG_STAT_BUSY]   = run;
    status_word[`DG_STAT_DONE]   = done_flag;
  end

  // --------------------------------------------------
  // bus handshake and control bits
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack     <= 1'b0;
      grad_wait  <= 1'b0;
      start_req  <= 1'b0;
      accumulate <= 1'b0;
    end else begin
      wb_ack    <= 1'b0;
      grad_wait <= 1'b0;
      start_req <= 1'b0;
      if (grad_wait) begin
        wb_ack <= 1'b1;
      end else if (req) begin
        // gradient reads take one extra cycle for the RAM
        if (is_grad && !wb_we) begin
          grad_wait <= 1'b1;
        end else begin
          wb_ack <= 1'b1;
        end
        if (wb_we && is_ctrl && state == IDLE) begin
          start_req  <= wb_dat_w[`DG_CTRL_START];
          accumulate <= wb_dat_w[`DG_CTRL_ACCUM];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grad_wait) begin
      wb_dat_r <= {{(WB_DAT_W-DATA_W){sel_grad[DATA_W-1]}}, sel_grad};
    end else if (req && !wb_we) begin
      if (is_ctrl) begin
        wb_dat_r <= ctrl_word;
      end else if (is_status) begin
        wb_dat_r <= status_word;
      end else begin
        wb_dat_r <= '0;
      end
    end
    if (req && is_grad) begin
      lane_sel <= grd_idx[LANE_W-1:0];
    end
  end

  // operand buffers frozen during a pass
  always_ff @(posedge clk) begin
    if (req && wb_we && !run) begin
      if (is_act) begin
        act_buf[act_idx*DATA_W +: DATA_W] <= wb_dat_w[DATA_W-1:0];
      end
      if (is_delta) begin
        delta_buf[dlt_idx*DATA_W +: DATA_W] <= wb_dat_w[DATA_W-1:0];
      end
    end
  end

  // --------------------------------------------------
  // run control
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      done_flag <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start_req) begin
            state     <= RUNNING;
            done_flag <= 1'b0;
          end
        end
        RUNNING: begin
          if (done) begin
            state     <= IDLE;
            done_flag <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign run = (state == RUNNING);

endmodule

// File: hdl/grad_ram.sv
module grad_ram #(
  parameter  int GRAD_LANES = 8,
  localparam int ADDR_W = $clog2(dense_grad_pkg::HID_DIM * dense_grad_pkg::CHAR_NUM / GRAD_LANES),
  localparam int WORD_W = GRAD_LANES * dense_grad_pkg::DATA_W
) (
  input  logic              clk,
  input  logic [ADDR_W-1:0] raddr,
  output logic [WORD_W-1:0] rdata,
  input  logic              wen,
  input  logic [ADDR_W-1:0] waddr,
  input  logic [WORD_W-1:0] wdata,
  input  logic [ADDR_W-1:0] host_raddr,
  output logic [WORD_W-1:0] host_rdata
);

  import dense_grad_pkg::*;

  localparam int DEPTH = HID_DIM * CHAR_NUM / GRAD_LANES;

  logic [WORD_W-1:0] mem [DEPTH];

  // engine side write
  always_ff @(posedge clk) begin
    if (wen) begin
      mem[waddr] <= wdata;
    end
  end

  // both read ports registered, old data on collision
  always_ff @(posedge clk) begin
    rdata      <= mem[raddr];
    host_rdata <= mem[host_raddr];
  end

endmodule

// File: hdl/dense_backward_grad.sv
module dense_backward_grad #(
  parameter  int GRAD_LANES = 8,
  localparam int ADDR_W = $clog2(dense_grad_pkg::HID_DIM * dense_grad_pkg::CHAR_NUM / GRAD_LANES),
  localparam int WORD_W = GRAD_LANES * dense_grad_pkg::DATA_W
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        run,
  input  logic                        accumulate,
  input  dense_grad_pkg::act_buf_t    act_buf,
  input  dense_grad_pkg::delta_buf_t  delta_buf,
  output logic [ADDR_W-1:0]           raddr,
  input  logic [WORD_W-1:0]           rdata,
  output logic                        wen,
  output logic [ADDR_W-1:0]           waddr,
  output logic [WORD_W-1:0]           wdata,
  output logic                        done
);

  import dense_grad_pkg::*;

  localparam int WORDS  = HID_DIM * CHAR_NUM / GRAD_LANES;
  localparam int GROUPS = CHAR_NUM / GRAD_LANES;
  localparam int HID_W  = $clog2(HID_DIM);
  localparam int GRP_W  = (GROUPS > 1) ? $clog2(GROUPS) : 1;
  // issue to write distance in cycles
  localparam int PIPE   = 5;
  localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(WORDS - 1);

  act_col_t          act_cols   [HID_DIM];
  delta_col_t        delta_cols [CHAR_NUM];
  delta_col_t        lane_delta [GRAD_LANES];
  act_col_t          cur_act;
  grad_t             inner_q    [GRAD_LANES];

  logic [HID_W-1:0]  hid_cnt;
  logic [GRP_W-1:0]  grp_cnt;
  logic [ADDR_W-1:0] issue_addr;
  logic              issue_end;
  logic              issuing;

  logic [ADDR_W-1:0] addr_d [PIPE];
  logic [PIPE-1:0]   flag_d;
  logic [WORD_W-1:0] rd_d1, rd_d2, rd_d3;

  // --------------------------------------------------
  // operand transpose
  // --------------------------------------------------
  for (genvar n = 0; n < BATCH_N; n++) begin : g_batch
    for (genvar h = 0; h < HID_DIM; h++) begin : g_act
      assign act_cols[h][n*DATA_W +: DATA_W] = act_buf[(n*HID_DIM + h)*DATA_W +: DATA_W];
    end
    for (genvar c = 0; c < CHAR_NUM; c++) begin : g_delta
      assign delta_cols[c][n*DATA_W +: DATA_W] = delta_buf[(n*CHAR_NUM + c)*DATA_W +: DATA_W];
    end
  end

  // all lanes see one hidden index, each lane its own output column
  assign cur_act = act_cols[hid_cnt];

  for (genvar i = 0; i < GRAD_LANES; i++) begin : g_lane
    assign lane_delta[i] = delta_cols[grp_cnt * GRAD_LANES + i];

    dense_inner u_inner (
      .clk       (clk),
      .rst_n     (rst_n),
      .act_col   (cur_act),
      .delta_col (lane_delta[i]),
      .q         (inner_q[i])
    );
  end

  // --------------------------------------------------
  // issue sequencing
  // --------------------------------------------------
  assign issuing = run & ~issue_end;
  assign raddr   = issue_addr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hid_cnt    <= '0;
      grp_cnt    <= '0;
      issue_addr <= '0;
      issue_end  <= 1'b0;
    end else if (!run) begin
      hid_cnt    <= '0;
      grp_cnt    <= '0;
      issue_addr <= '0;
      issue_end  <= 1'b0;
    end else if (issue_addr != LAST_ADDR) begin
      issue_addr <= issue_addr + 1'b1;
      if (grp_cnt == GRP_W'(GROUPS - 1)) begin
        grp_cnt <= '0;
        hid_cnt <= hid_cnt + 1'b1;
      end else begin
        grp_cnt <= grp_cnt + 1'b1;
      end
    end else begin
      // last word goes out this cycle
      issue_end <= 1'b1;
    end
  end

  // --------------------------------------------------
  // alignment of address, flags and read data
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    addr_d[0] <= issue_addr;
    for (int s = 1; s < PIPE; s++) begin
      addr_d[s] <= addr_d[s-1];
    end
    // memory data lands one cycle after issue, q four cycles after
    rd_d1 <= rdata;
    rd_d2 <= rd_d1;
    rd_d3 <= rd_d2;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flag_d <= '0;
      done   <= 1'b0;
    end else begin
      flag_d <= {flag_d[PIPE-2:0], issuing};
      done   <= wen && (waddr == LAST_ADDR);
    end
  end

  assign wen   = flag_d[PIPE-1];
  assign waddr = addr_d[PIPE-1];

  // read-modify-write, adds wrap at 16 bits
  always_ff @(posedge clk) begin
    for (int i = 0; i < GRAD_LANES; i++) begin
      if (accumulate) begin
        wdata[i*DATA_W +: DATA_W] <= rd_d3[i*DATA_W +: DATA_W] + inner_q[i];
      end else begin
        wdata[i*DATA_W +: DATA_W] <= inner_q[i];
      end
    end
  end

endmodule

// File: hdl/dense_inner.sv
module dense_inner (
  input  logic                        clk,
  input  logic                        rst_n,
  input  dense_grad_pkg::act_col_t    act_col,
  input  dense_grad_pkg::delta_col_t  delta_col,
  output dense_grad_pkg::grad_t       q
);

  import dense_grad_pkg::*;

  localparam int PAIRS = BATCH_N / 2;

  act_col_t   act_r;
  delta_col_t delta_r;
  prod_t      prod [BATCH_N];
  prod_t      pair [PAIRS];
  prod_t      total;

  // --------------------------------------------------
  // four stage pipeline, one new pair per cycle
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      act_r   <= '0;
      delta_r <= '0;
      q       <= '0;
      for (int n = 0; n < BATCH_N; n++) begin
        prod[n] <= '0;
      end
      for (int p = 0; p < PAIRS; p++) begin
        pair[p] <= '0;
      end
    end else begin
      // operand capture
      act_r   <= act_col;
      delta_r <= delta_col;
      // signed products per sample
      for (int n = 0; n < BATCH_N; n++) begin
        prod[n] <= act_t'(act_r[n*DATA_W +: DATA_W]) * delta_t'(delta_r[n*DATA_W +: DATA_W]);
      end
      for (int p = 0; p < PAIRS; p++) begin
        pair[p] <= prod[2*p] + prod[2*p+1];
      end
      // drop fraction bits, low 16 bits kept
      q <= grad_t'(total >>> FRAC_BITS);
    end
  end

  always_comb begin
    total = '0;
    for (int p = 0; p < PAIRS; p++) begin
      total = total + pair[p];
    end
  end

endmodule

// File: hdl/dense_grad_pkg.sv
package dense_grad_pkg;

  // --------------------------------------------------
  // layer dimensions
  // --------------------------------------------------
  localparam int BATCH_N  = 4;
  localparam int HID_DIM  = 8;
  localparam int CHAR_NUM = 16;

  // fixed point, 16 bit signed with 8 fraction bits
  localparam int DATA_W    = 16;
  localparam int FRAC_BITS = 8;
  localparam int PROD_W    = 2 * DATA_W;

  // host bus widths
  localparam int WB_ADR_W = 12;
  localparam int WB_DAT_W = 32;

  // --------------------------------------------------
  // scalar types
  // --------------------------------------------------
  typedef logic signed [DATA_W-1:0] act_t;
  typedef logic signed [DATA_W-1:0] delta_t;
  typedef logic signed [DATA_W-1:0] grad_t;
  typedef logic signed [PROD_W-1:0] prod_t;

  // one column holds the same index over the whole batch
  typedef logic [BATCH_N*DATA_W-1:0] act_col_t;
  typedef logic [BATCH_N*DATA_W-1:0] delta_col_t;

  // full operand buffers, sample-major
  typedef logic [BATCH_N*HID_DIM*DATA_W-1:0]  act_buf_t;
  typedef logic [BATCH_N*CHAR_NUM*DATA_W-1:0] delta_buf_t;

  typedef logic [WB_ADR_W-1:0] wb_adr_t;
  typedef logic [WB_DAT_W-1:0] wb_dat_t;

endpackage

// File: include/dense_grad_map.svh
`ifndef DENSE_GRAD_MAP_SVH
`define DENSE_GRAD_MAP_SVH

// register word addresses
`define DG_CTRL_ADDR   12'h000
`define DG_STATUS_ADDR 12'h001

// operand and result windows, one word per element
`define DG_ACT_BASE    12'h100
`define DG_DELTA_BASE  12'h200
`define DG_GRAD_BASE   12'h400

// CTRL bits, start clears itself
`define DG_CTRL_START  0
`define DG_CTRL_ACCUM  1

// STATUS bits
`define DG_STAT_BUSY   0
`define DG_STAT_DONE   1

`endif
